//--- src/rv_decode_pkg.sv
package rv_decode_pkg;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // non-CSR SYSTEM encodings, imm12 field
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;
  localparam logic [11:0] F12_DRET   = 12'h7b2;
  localparam logic [11:0] F12_WFI    = 12'h105;

  // multiply/divide operator
  localparam logic [1:0] MD_MULL = 2'd0;
  localparam logic [1:0] MD_MULH = 2'd1;
  localparam logic [1:0] MD_DIV  = 2'd2;
  localparam logic [1:0] MD_REM  = 2'd3;

  localparam logic [1:0] CSR_READ  = 2'd0;
  localparam logic [1:0] CSR_WRITE = 2'd1;
  localparam logic [1:0] CSR_SET   = 2'd2;
  localparam logic [1:0] CSR_CLEAR = 2'd3;

  localparam logic [1:0] SIZE_W = 2'd0;
  localparam logic [1:0] SIZE_H = 2'd1;
  localparam logic [1:0] SIZE_B = 2'd2;

  //////////////////////////////////////////////////
  // control word layout, bits 26:24 reserved
  //////////////////////////////////////////////////
  localparam int CTRL_W = 27;

  localparam int B_ILLEGAL       = 0;
  localparam int B_ECALL         = 1;
  localparam int B_EBREAK        = 2;
  localparam int B_MRET          = 3;
  localparam int B_DRET          = 4;
  localparam int B_WFI           = 5;
  localparam int B_JUMP          = 6;
  localparam int B_BRANCH        = 7;
  localparam int B_FENCE_I       = 8;
  localparam int B_RF_WE         = 9;
  localparam int B_RF_WDATA_CSR  = 10;
  localparam int B_CSR_ACCESS    = 11;
  localparam int B_CSR_OP        = 12; // 2 bits
  localparam int B_MD_OP         = 14; // 2 bits
  localparam int B_MD_SIGNED     = 16; // 2 bits
  localparam int B_DATA_REQ      = 18;
  localparam int B_DATA_WE       = 19;
  localparam int B_DATA_TYPE     = 20; // 2 bits
  localparam int B_DATA_SIGN_EXT = 22;
  localparam int B_RS1_ZERO      = 23;

  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W    = 3;

  // R-type and I-type views of one instruction word
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_instr_u;

endpackage

//--- src/md_decode.sv
module md_decode (
  input  logic [6:0] funct7_i,
  input  logic [2:0] funct3_i,
  output logic       legal_o,
  output logic [1:0] md_op_o,
  output logic [1:0] md_signed_o
);
  import rv_decode_pkg::*;

  always_comb begin
    legal_o     = 1'b1;
    md_op_o     = MD_MULL;
    md_signed_o = 2'b00;
    case ({funct7_i, funct3_i})
      // RV32I register-register
      {7'b000_0000, 3'b000}, {7'b010_0000, 3'b000},  // add, sub
      {7'b000_0000, 3'b001}, {7'b000_0000, 3'b010},  // sll, slt
      {7'b000_0000, 3'b011}, {7'b000_0000, 3'b100},  // sltu, xor
      {7'b000_0000, 3'b101}, {7'b010_0000, 3'b101},  // srl, sra
      {7'b000_0000, 3'b110}, {7'b000_0000, 3'b111}: ; // or, and

      // RV32M
      {7'b000_0001, 3'b000}: md_op_o = MD_MULL;
      {7'b000_0001, 3'b001}: begin md_op_o = MD_MULH; md_signed_o = 2'b11; end
      {7'b000_0001, 3'b010}: begin md_op_o = MD_MULH; md_signed_o = 2'b01; end
      {7'b000_0001, 3'b011}: md_op_o = MD_MULH;         // mulhu
      {7'b000_0001, 3'b100}: begin md_op_o = MD_DIV; md_signed_o = 2'b11; end
      {7'b000_0001, 3'b101}: md_op_o = MD_DIV;          // divu
      {7'b000_0001, 3'b110}: begin md_op_o = MD_REM; md_signed_o = 2'b11; end
      {7'b000_0001, 3'b111}: md_op_o = MD_REM;          // remu
      default: legal_o = 1'b0;
    endcase
  end

endmodule

//--- src/rv_decoder.sv
module rv_decoder (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              instr_valid_i,
  input  rv_decode_pkg::rv_instr_u          instr_i,
  output logic                              instr_ready_o,
  input  logic                              q_credit_i,
  output logic                              q_push_o,
  output logic [rv_decode_pkg::CTRL_W-1:0]  q_wdata_o
);
  import rv_decode_pkg::*;

  logic [CREDIT_W-1:0] credits;
  logic [2:0] funct3;
  logic md_legal;
  logic [1:0] md_op_dec, md_signed_dec;

  logic illegal, ecall, ebreak, mret, dret, wfi;
  logic jump, branch, fence_i, rf_we, rf_wdata_csr, csr_access;
  logic [1:0] csr_op, md_op, md_signed, data_type;
  logic data_req, data_we, data_sign_ext;

  assign funct3 = instr_i.i.funct3;

  md_decode md_decode_inst (
    .funct7_i    (instr_i.r.funct7),
    .funct3_i    (instr_i.r.funct3),
    .legal_o     (md_legal),
    .md_op_o     (md_op_dec),
    .md_signed_o (md_signed_dec)
  );

  //////////////////////////////////////////////////
  // opcode decode
  //////////////////////////////////////////////////
  always_comb begin
    illegal       = 1'b0;
    ecall         = 1'b0;
    ebreak        = 1'b0;
    mret          = 1'b0;
    dret          = 1'b0;
    wfi           = 1'b0;
    jump          = 1'b0;
    branch        = 1'b0;
    fence_i       = 1'b0;
    rf_we         = 1'b0;
    rf_wdata_csr  = 1'b0;
    csr_access    = 1'b0;
    csr_op        = CSR_READ;
    md_op         = MD_MULL;
    md_signed     = 2'b00;
    data_req      = 1'b0;
    data_we       = 1'b0;
    data_type     = SIZE_W;
    data_sign_ext = 1'b0;

    case (instr_i.r.opcode)
      OPC_JAL: begin
        jump  = 1'b1;
        rf_we = 1'b1;  // link written in the same step
      end
      OPC_JALR: begin
        jump    = 1'b1;
        rf_we   = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        branch  = 1'b1;
        illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_STORE: begin
        data_req = 1'b1;
        data_we  = 1'b1;
        illegal  = funct3[2];
        case (funct3[1:0])
          2'b00:   data_type = SIZE_B;
          2'b01:   data_type = SIZE_H;
          2'b10:   data_type = SIZE_W;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        data_req      = 1'b1;
        data_sign_ext = ~funct3[2];  // lbu/lhu zero extend
        case (funct3[1:0])
          2'b00:   data_type = SIZE_B;
          2'b01:   data_type = SIZE_H;
          2'b10:   illegal = funct3[2];  // no lwu on rv32
          default: illegal = 1'b1;
        endcase
      end
      OPC_LUI, OPC_AUIPC: rf_we = 1'b1;
      OPC_OP_IMM: begin
        rf_we = 1'b1;
        // only plain shifts, no bit-manip encodings
        if (funct3 == 3'b001) begin
          illegal = (instr_i.r.funct7 != 7'b000_0000);
        end else if (funct3 == 3'b101) begin
          illegal = (instr_i.r.funct7 != 7'b000_0000) && (instr_i.r.funct7 != 7'b010_0000);
        end
      end
      OPC_OP: begin
        rf_we     = 1'b1;
        illegal   = ~md_legal;
        md_op     = md_op_dec;
        md_signed = md_signed_dec;
      end
      OPC_MISC_MEM: begin
        case (funct3)
          3'b000: ;  // fence, nop here
          3'b001: begin
            jump    = 1'b1;  // refetch after fence.i
            fence_i = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (instr_i.i.imm12)
            F12_ECALL:  ecall  = 1'b1;
            F12_EBREAK: ebreak = 1'b1;
            F12_MRET:   mret   = 1'b1;
            F12_DRET:   dret   = 1'b1;
            F12_WFI:    wfi    = 1'b1;
            default:    illegal = 1'b1;
          endcase
          if (instr_i.i.rs1 != 5'd0 || instr_i.i.rd != 5'd0) begin
            illegal = 1'b1;
          end
        end else begin
          csr_access   = 1'b1;
          rf_wdata_csr = 1'b1;
          rf_we        = 1'b1;
          case (funct3[1:0])
            2'b01:   csr_op = CSR_WRITE;
            2'b10:   csr_op = CSR_SET;
            2'b11:   csr_op = CSR_CLEAR;
            default: illegal = 1'b1;
          endcase
        end
      end
      default: illegal = 1'b1;
    endcase

    // no side effects past this stage
    if (illegal) begin
      rf_we      = 1'b0;
      data_req   = 1'b0;
      data_we    = 1'b0;
      jump       = 1'b0;
      branch     = 1'b0;
      csr_access = 1'b0;
    end
  end

  always_comb begin
    q_wdata_o                      = '0;
    q_wdata_o[B_ILLEGAL]           = illegal;
    q_wdata_o[B_ECALL]             = ecall;
    q_wdata_o[B_EBREAK]            = ebreak;
    q_wdata_o[B_MRET]              = mret;
    q_wdata_o[B_DRET]              = dret;
    q_wdata_o[B_WFI]               = wfi;
    q_wdata_o[B_JUMP]              = jump;
    q_wdata_o[B_BRANCH]            = branch;
    q_wdata_o[B_FENCE_I]           = fence_i;
    q_wdata_o[B_RF_WE]             = rf_we;
    q_wdata_o[B_RF_WDATA_CSR]      = rf_wdata_csr;
    q_wdata_o[B_CSR_ACCESS]        = csr_access;
    q_wdata_o[B_CSR_OP +: 2]       = csr_op;
    q_wdata_o[B_MD_OP +: 2]        = md_op;
    q_wdata_o[B_MD_SIGNED +: 2]    = md_signed;
    q_wdata_o[B_DATA_REQ]          = data_req;
    q_wdata_o[B_DATA_WE]           = data_we;
    q_wdata_o[B_DATA_TYPE +: 2]    = data_type;
    q_wdata_o[B_DATA_SIGN_EXT]     = data_sign_ext;
    q_wdata_o[B_RS1_ZERO]          = (instr_i.i.rs1 == 5'd0);
  end

  //////////////////////////////////////////////////
  // credit counter
  //////////////////////////////////////////////////
  assign instr_ready_o = (credits != '0);
  assign q_push_o      = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits <= CREDIT_W'(QUEUE_DEPTH);
    end else if (q_push_o && !q_credit_i) begin
      credits <= credits - 1'b1;
    end else if (q_credit_i && !q_push_o) begin
      credits <= credits + 1'b1;
    end
  end

  // returned credits never overrun the queue size
  a_push_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    q_push_o |-> (credits != '0) && (credits <= CREDIT_W'(QUEUE_DEPTH)));

endmodule

//--- src/dec_queue.sv
module dec_queue #(
  parameter int WIDTH = 27,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic             pop_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] rdata_o,
  output logic             credit_o
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;

  assign valid_o = (count != '0);
  assign rdata_o = mem[rd_ptr];  // head entry

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop_i;  // one credit back per pop
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  // producer credits must keep us from overflowing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> count != CNT_W'(DEPTH));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> valid_o);

endmodule

//--- src/dec_issue.sv
module dec_issue (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             q_valid_i,
  input  logic [rv_decode_pkg::CTRL_W-1:0] q_rdata_i,
  output logic                             q_pop_o,
  input  logic                             dec_ready_i,
  output logic                             dec_valid_o,
  output logic                             illegal_o,
  output logic                             ecall_o,
  output logic                             ebreak_o,
  output logic                             mret_o,
  output logic                             dret_o,
  output logic                             wfi_o,
  output logic                             jump_o,
  output logic                             branch_o,
  output logic                             fence_i_o,
  output logic                             rf_we_o,
  output logic                             rf_wdata_csr_o,
  output logic                             csr_access_o,
  output logic [1:0]                       csr_op_o,
  output logic [1:0]                       md_op_o,
  output logic [1:0]                       md_signed_o,
  output logic                             data_req_o,
  output logic                             data_we_o,
  output logic [1:0]                       data_type_o,
  output logic                             data_sign_ext_o
);
  import rv_decode_pkg::*;

  logic [CTRL_W-1:0] ctrl_q;
  logic [CTRL_W-1:0] ctrl_d;
  logic [1:0]        head_csr_op;

  // load when empty or being taken this cycle
  assign q_pop_o = q_valid_i & (~dec_valid_o | dec_ready_i);

  //////////////////////////////////////////////////
  // CSR operand check
  //////////////////////////////////////////////////
  assign head_csr_op = q_rdata_i[B_CSR_OP +: 2];

  always_comb begin
    ctrl_d = q_rdata_i;
    // set/clear from x0 only reads the CSR
    if (q_rdata_i[B_RS1_ZERO] && (head_csr_op == CSR_SET || head_csr_op == CSR_CLEAR)) begin
      ctrl_d[B_CSR_OP +: 2] = CSR_READ;
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_pop_o) begin
      ctrl_q <= ctrl_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_valid_o <= 1'b0;
    end else if (q_pop_o) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  assign illegal_o       = ctrl_q[B_ILLEGAL];
  assign ecall_o         = ctrl_q[B_ECALL];
  assign ebreak_o        = ctrl_q[B_EBREAK];
  assign mret_o          = ctrl_q[B_MRET];
  assign dret_o          = ctrl_q[B_DRET];
  assign wfi_o           = ctrl_q[B_WFI];
  assign jump_o          = ctrl_q[B_JUMP];
  assign branch_o        = ctrl_q[B_BRANCH];
  assign fence_i_o       = ctrl_q[B_FENCE_I];
  assign rf_we_o         = ctrl_q[B_RF_WE];
  assign rf_wdata_csr_o  = ctrl_q[B_RF_WDATA_CSR];
  assign csr_access_o    = ctrl_q[B_CSR_ACCESS];
  assign csr_op_o        = ctrl_q[B_CSR_OP +: 2];
  assign md_op_o         = ctrl_q[B_MD_OP +: 2];
  assign md_signed_o     = ctrl_q[B_MD_SIGNED +: 2];
  assign data_req_o      = ctrl_q[B_DATA_REQ];
  assign data_we_o       = ctrl_q[B_DATA_WE];
  assign data_type_o     = ctrl_q[B_DATA_TYPE +: 2];
  assign data_sign_ext_o = ctrl_q[B_DATA_SIGN_EXT];

  // stalled output holds its value
  a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(ctrl_q));

endmodule

//--- src/rv_decode_top.sv
module rv_decode_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     instr_valid_i,
  input  rv_decode_pkg::rv_instr_u instr_i,
  output logic                     instr_ready_o,
  input  logic                     dec_ready_i,
  output logic                     dec_valid_o,
  output logic                     illegal_o,
  output logic                     ecall_o,
  output logic                     ebreak_o,
  output logic                     mret_o,
  output logic                     dret_o,
  output logic                     wfi_o,
  output logic                     jump_o,
  output logic                     branch_o,
  output logic                     fence_i_o,
  output logic                     rf_we_o,
  output logic                     rf_wdata_csr_o,
  output logic                     csr_access_o,
  output logic [1:0]               csr_op_o,
  output logic [1:0]               md_op_o,
  output logic [1:0]               md_signed_o,
  output logic                     data_req_o,
  output logic                     data_we_o,
  output logic [1:0]               data_type_o,
  output logic                     data_sign_ext_o
);
  import rv_decode_pkg::*;

  logic              q_push, q_credit, q_valid, q_pop;
  logic [CTRL_W-1:0] q_wdata, q_rdata;

  rv_decoder rv_decoder_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .q_credit_i    (q_credit),
    .q_push_o      (q_push),
    .q_wdata_o     (q_wdata)
  );

  dec_queue #(.WIDTH(CTRL_W), .DEPTH(QUEUE_DEPTH)) dec_queue_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .push_i   (q_push),
    .wdata_i  (q_wdata),
    .pop_i    (q_pop),
    .valid_o  (q_valid),
    .rdata_o  (q_rdata),
    .credit_o (q_credit)
  );

  dec_issue dec_issue_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .q_valid_i       (q_valid),
    .q_rdata_i       (q_rdata),
    .q_pop_o         (q_pop),
    .dec_ready_i     (dec_ready_i),
    .dec_valid_o     (dec_valid_o),
    .illegal_o       (illegal_o),
    .ecall_o         (ecall_o),
    .ebreak_o        (ebreak_o),
    .mret_o          (mret_o),
    .dret_o          (dret_o),
    .wfi_o           (wfi_o),
    .jump_o          (jump_o),
    .branch_o        (branch_o),
    .fence_i_o       (fence_i_o),
    .rf_we_o         (rf_we_o),
    .rf_wdata_csr_o  (rf_wdata_csr_o),
    .csr_access_o    (csr_access_o),
    .csr_op_o        (csr_op_o),
    .md_op_o         (md_op_o),
    .md_signed_o     (md_signed_o),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_type_o     (data_type_o),
    .data_sign_ext_o (data_sign_ext_o)
  );

endmodule

//--- tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int N_TMPL = 35;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

//////////////////////////////////////////////////
// instruction templates as {random mask, base}
//////////////////////////////////////////////////
function automatic logic [63:0] instr_template(input int idx);
  case (idx)
    0:  return {32'hFFFF_FF80, 32'h0000_0037};  // lui
    1:  return {32'hFFFF_FF80, 32'h0000_0017};  // auipc
    2:  return {32'hFFFF_FF80, 32'h0000_006F};  // jal
    3:  return {32'hFFFF_8F80, 32'h0000_0067};  // jalr
    4:  return {32'hFFFF_8F80, 32'h0000_1067};  // jalr with bad funct3
    5:  return {32'hFFFF_FF80, 32'h0000_0063};  // branch with any funct3
    6:  return {32'hFFFF_FF80, 32'h0000_0003};  // load with any funct3
    7:  return {32'hFFFF_8F80, 32'h0000_6003};  // lwu
    8:  return {32'hFFFF_FF80, 32'h0000_0023};  // store with any funct3
    9:  return {32'hFFFF_8F80, 32'h0000_0013};  // addi
    10: return {32'hFFFF_8F80, 32'h0000_6013};  // ori
    11: return {32'h01FF_8F80, 32'h0000_1013};  // slli
    12: return {32'hFFFF_8F80, 32'h0000_1013};  // slli with random funct7
    13: return {32'h01FF_8F80, 32'h0000_5013};  // srli
    14: return {32'h01FF_8F80, 32'h4000_5013};  // srai
    15: return {32'hFFFF_8F80, 32'h0000_5013};  // right shift with random funct7
    16: return {32'h01FF_FF80, 32'h0000_0033};  // op with funct7 zero
    17: return {32'h01FF_FF80, 32'h4000_0033};  // op with funct7 0x20
    18: return {32'h01FF_FF80, 32'h0200_0033};  // rv32m
    19: return {32'hFFFF_FF80, 32'h0000_0033};  // op with mostly unknown funct7
    20: return {32'hFFFF_8F80, 32'h0000_000F};  // fence
    21: return {32'hFFFF_8F80, 32'h0000_100F};  // fence.i
    22: return {32'hFFFF_FF80, 32'h0000_000F};  // misc-mem with any funct3
    23: return {32'h0000_0000, 32'h0000_0073};  // ecall
    24: return {32'h0000_0000, 32'h0010_0073};  // ebreak
    25: return {32'h0000_0000, 32'h3020_0073};  // mret
    26: return {32'h0000_0000, 32'h7B20_0073};  // dret
    27: return {32'h0000_0000, 32'h1050_0073};  // wfi
    28: return {32'h000F_8F80, 32'h0000_0073};  // ecall with rs1/rd noise
    29: return {32'hFFF0_0000, 32'h0000_0073};  // random funct12
    30: return {32'hFFFF_FF80, 32'h0000_1073};  // csr with any funct3
    31: return {32'hFFF0_0F80, 32'h0000_2073};  // csrrs from x0
    32: return {32'hFFF0_0F80, 32'h0000_3073};  // csrrc from x0
    33: return {32'hFFFF_8F80, 32'h0000_4073};  // csr funct3 100
    34: return {32'hFFFF_FFFF, 32'h0000_0000};  // random word, mostly bad opcodes
    default: return {32'hFFFF_FFFF, 32'h0000_0000};
  endcase
endfunction

function automatic logic [31:0] build_instr(input int idx, input logic [31:0] rnd);
  logic [63:0] t;
  t = instr_template(idx);
  return (t[31:0] & ~t[63:32]) | (rnd & t[63:32]);
endfunction

function automatic logic [1:0] size_of(input logic [1:0] f);
  if (f == 2'b00) return SIZE_B;
  if (f == 2'b01) return SIZE_H;
  return SIZE_W;
endfunction

// expected outputs from illegal at bit 22 down to data_sign_ext at bit 0
function automatic logic [22:0] ref_decode(input logic [31:0] w);
  logic [6:0]  opc, f7;
  logic [2:0]  f3;
  logic [4:0]  rs1, rd;
  logic [11:0] f12;
  logic ill, ec, eb, mr, dr, wf, jmp, br, fi, we, wcsr, csr, req, dwe, sx;
  logic [1:0] cop, mop, msg, dt;
  opc = w[6:0];
  rd  = w[11:7];
  f3  = w[14:12];
  rs1 = w[19:15];
  f7  = w[31:25];
  f12 = w[31:20];
  {ill, ec, eb, mr, dr, wf, jmp, br, fi, we, wcsr, csr, req, dwe, sx} = '0;
  cop = CSR_READ;
  mop = MD_MULL;
  msg = 2'b00;
  dt  = SIZE_W;
  case (opc)
    7'b0110111, 7'b0010111: we = 1'b1;  // lui, auipc
    7'b1101111: {jmp, we} = 2'b11;
    7'b1100111: begin
      {jmp, we} = 2'b11;
      ill = (f3 != 3'd0);
    end
    7'b1100011: begin
      br  = 1'b1;
      ill = (f3 == 3'd2) || (f3 == 3'd3);
    end
    7'b0000011: begin  // load
      req = 1'b1;
      sx  = ~f3[2];
      dt  = size_of(f3[1:0]);
      ill = (f3 == 3'd3) || (f3[2:1] == 2'b11);
    end
    7'b0100011: begin  // store
      {req, dwe} = 2'b11;
      dt  = size_of(f3[1:0]);
      ill = f3[2] || (f3[1:0] == 2'b11);
    end
    7'b0010011: begin  // op-imm
      we = 1'b1;
      if (f3 == 3'd1) ill = (f7 != 7'h00);
      if (f3 == 3'd5) ill = (f7 != 7'h00) && (f7 != 7'h20);
    end
    7'b0110011: begin
      we = 1'b1;
      if (f7 == 7'h01) begin
        mop = f3[2] ? (f3[1] ? MD_REM : MD_DIV) : ((f3[1:0] == 2'b00) ? MD_MULL : MD_MULH);
        if (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd6) msg = 2'b11;
        else if (f3 == 3'd2) msg = 2'b01;
      end else if (f7 == 7'h20) begin
        ill = !(f3 == 3'd0 || f3 == 3'd5);
      end else begin
        ill = (f7 != 7'h00);
      end
    end
    7'b0001111: begin
      if (f3 == 3'd1) {jmp, fi} = 2'b11;
      else ill = (f3 != 3'd0);
    end
    7'b1110011: begin
      if (f3 == 3'd0) begin
        ec  = (f12 == 12'h000);
        eb  = (f12 == 12'h001);
        mr  = (f12 == 12'h302);
        dr  = (f12 == 12'h7B2);
        wf  = (f12 == 12'h105);
        ill = !(ec | eb | mr | dr | wf) || (rs1 != 5'd0) || (rd != 5'd0);
      end else begin
        {csr, wcsr, we} = 3'b111;
        case (f3[1:0])
          2'b01:   cop = CSR_WRITE;
          2'b10:   cop = CSR_SET;
          2'b11:   cop = CSR_CLEAR;
          default: ill = 1'b1;
        endcase
        if (rs1 == 5'd0 && (cop == CSR_SET || cop == CSR_CLEAR)) cop = CSR_READ;
      end
    end
    default: ill = 1'b1;
  endcase
  if (ill) {we, req, dwe, jmp, br, csr} = '0;
  return {ill, ec, eb, mr, dr, wf, jmp, br, fi, we, wcsr, csr, cop, mop, msg, req, dwe, dt, sx};
endfunction

`endif

//--- tests/tb_rv_decode.sv
module tb_rv_decode;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_decode_pkg::*;

  localparam int SEND_LIMIT  = 64;
  localparam int DRAIN_LIMIT = 400;
  localparam int N_RANDOM    = 500;
  localparam int READY_LOW   = 0;
  localparam int READY_RAND  = 1;
  localparam int READY_HIGH  = 2;

  logic clk_i, rst_i, instr_valid_i, instr_ready_o, dec_ready_i, dec_valid_o;
  rv_instr_u instr_i;
  logic illegal_o, ecall_o, ebreak_o, mret_o, dret_o, wfi_o, jump_o, branch_o;
  logic fence_i_o, rf_we_o, rf_wdata_csr_o, csr_access_o;
  logic data_req_o, data_we_o, data_sign_ext_o;
  logic [1:0] csr_op_o, md_op_o, md_signed_o, data_type_o;

  logic [22:0] exp_q[$];
  logic [31:0] word_q[$];
  logic [31:0] rng;
  logic [31:0] cur_word;
  int ready_mode;
  int accepted_count;
  int taken_count;

  `include "tb_ref_model.svh"

  rv_decode_top rv_decode_top_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .instr_valid_i(instr_valid_i), .instr_i(instr_i), .instr_ready_o(instr_ready_o),
    .dec_ready_i(dec_ready_i), .dec_valid_o(dec_valid_o),
    .illegal_o(illegal_o), .ecall_o(ecall_o), .ebreak_o(ebreak_o), .mret_o(mret_o),
    .dret_o(dret_o), .wfi_o(wfi_o), .jump_o(jump_o), .branch_o(branch_o),
    .fence_i_o(fence_i_o), .rf_we_o(rf_we_o), .rf_wdata_csr_o(rf_wdata_csr_o),
    .csr_access_o(csr_access_o), .csr_op_o(csr_op_o), .md_op_o(md_op_o),
    .md_signed_o(md_signed_o), .data_req_o(data_req_o), .data_we_o(data_we_o),
    .data_type_o(data_type_o), .data_sign_ext_o(data_sign_ext_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h (instr 0x%08h)", name, got, exp, cur_word);
      abort_run();
    end
  endtask

  task automatic check_pair(input string name, input logic [1:0] got, input logic [1:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h (instr 0x%08h)", name, got, exp, cur_word);
      abort_run();
    end
  endtask

  task automatic drive_ready();
    if (ready_mode == READY_LOW) begin
      dec_ready_i = 1'b0;
    end else if (ready_mode == READY_HIGH) begin
      dec_ready_i = 1'b1;
    end else begin
      rng = xorshift32(rng);
      dec_ready_i = (rng[1:0] != 2'b00);
    end
  endtask

  task automatic pick_word(output logic [31:0] word);
    int idx;
    rng  = xorshift32(rng);
    idx  = int'(rng % N_TMPL);
    rng  = xorshift32(rng);
    word = build_instr(idx, rng);
  endtask

  // called at a falling edge, returns at one
  task automatic send_instr(input logic [31:0] word);
    int waited;
    bit accepted;
    waited = 0;
    accepted = 1'b0;
    instr_valid_i = 1'b1;
    instr_i = word;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = instr_ready_o;
      @(negedge clk_i);
      drive_ready();
      waited++;
      assert (accepted || waited < SEND_LIMIT) else begin
        $display("instruction 0x%08h was not accepted within %0d cycles", word, SEND_LIMIT);
        abort_run();
      end
    end
    exp_q.push_back(ref_decode(word));
    word_q.push_back(word);
    accepted_count++;
    instr_valid_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    instr_valid_i = 1'b0;
    for (int k = 0; k < n; k++) begin
      @(negedge clk_i);
      drive_ready();
    end
  endtask

  //////////////////////////////////////////////////
  // compare taken outputs against the scoreboard
  //////////////////////////////////////////////////
  always @(posedge clk_i) begin : compare_outputs
    logic [22:0] e;
    if (!rst_i && dec_valid_o && dec_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("an output was taken with no accepted instruction pending");
        abort_run();
      end
      e = exp_q.pop_front();
      cur_word = word_q.pop_front();
      taken_count++;
      check_bit("illegal_o", illegal_o, e[22]);
      check_bit("ecall_o", ecall_o, e[21]);
      check_bit("ebreak_o", ebreak_o, e[20]);
      check_bit("mret_o", mret_o, e[19]);
      check_bit("dret_o", dret_o, e[18]);
      check_bit("wfi_o", wfi_o, e[17]);
      check_bit("jump_o", jump_o, e[16]);
      check_bit("branch_o", branch_o, e[15]);
      check_bit("fence_i_o", fence_i_o, e[14]);
      check_bit("rf_we_o", rf_we_o, e[13]);
      check_bit("rf_wdata_csr_o", rf_wdata_csr_o, e[12]);
      check_bit("csr_access_o", csr_access_o, e[11]);
      check_pair("csr_op_o", csr_op_o, e[10:9]);
      check_pair("md_op_o", md_op_o, e[8:7]);
      check_pair("md_signed_o", md_signed_o, e[6:5]);
      check_bit("data_req_o", data_req_o, e[4]);
      check_bit("data_we_o", data_we_o, e[3]);
      check_pair("data_type_o", data_type_o, e[2:1]);
      check_bit("data_sign_ext_o", data_sign_ext_o, e[0]);
    end
  end

  initial begin : stimulus
    logic [31:0] word;
    int waited;
    rst_i = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;
    dec_ready_i = 1'b0;
    rng = 32'd34211;
    ready_mode = READY_LOW;
    accepted_count = 0;
    taken_count = 0;
    cur_word = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    assert (instr_ready_o === 1'b1 && dec_valid_o === 1'b0) else begin
      $display("DUT is not idle after reset");
      abort_run();
    end

    // output stalled, queue plus output register fill up
    for (int n = 0; n < QUEUE_DEPTH + 1; n++) begin
      pick_word(word);
      send_instr(word);
    end
    pick_word(word);
    instr_valid_i = 1'b1;
    instr_i = word;
    for (int n = 0; n < 12; n++) begin
      @(posedge clk_i);
      assert (instr_ready_o === 1'b0) else begin
        $display("[ERROR] instr_ready_o got 0x%0h expected 0x0 while full", instr_ready_o);
        abort_run();
      end
      @(negedge clk_i);
    end
    ready_mode = READY_RAND;
    send_instr(word);

    ///////////////////////////////////////////////
    // random stream with random back-pressure
    ///////////////////////////////////////////////
    for (int n = 0; n < N_RANDOM; n++) begin
      pick_word(word);
      send_instr(word);
      rng = xorshift32(rng);
      if (rng[3:0] == 4'd0) idle_cycles(int'(rng[5:4]) + 1);
    end

    ready_mode = READY_HIGH;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      drive_ready();
      waited++;
    end
    @(negedge clk_i);
    if (exp_q.size() == 0 && taken_count == accepted_count && dec_valid_o === 1'b0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("drain incomplete after %0d cycles, %0d accepted and %0d taken",
               waited, accepted_count, taken_count);
      abort_run();
    end
  end

endmodule

//--- src.f
+incdir+tests
src/rv_decode_pkg.sv
src/md_decode.sv
src/rv_decoder.sv
src/dec_queue.sv
src/dec_issue.sv
src/rv_decode_top.sv
tests/tb_rv_decode.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_rv_decode

out=$(./obj_dir/Vtb_rv_decode 2>&1 || true)
echo "$out"

if grep -q "All checks passed" <<< "$out"; then
  exit 0
fi
exit 1
